//--- build.f
+incdir+verilog
verilog/ecc_pkg.sv
verilog/bus_pkg.sv
verilog/hamming_encoder.sv
verilog/hamming_decoder.sv
verilog/port_arbiter.sv
verilog/codeword_ram.sv
verilog/ecc_mem_top.sv
tests/ecc_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ECC memory testbench with Verilator

# Paths in build.f are relative to the project root
cd "$(dirname "$0")" || exit 1

# Compile RTL and testbench into one executable
verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module ecc_mem_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

# Run once, keep the output for the search below
out=$(./obj_dir/Vecc_mem_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# A clean exit without the pass line still counts as a failure
if echo "$out" | grep -q "All checks passed"; then
	exit 0
fi
exit 1

//--- tests/ecc_mem_tb.sv
`include "ecc_consts.svh"

module ecc_mem_tb;

	import ecc_pkg::*;
	import bus_pkg::*;

	// Cycles a port waits for its own response
	localparam int RSP_TIMEOUT = 40;
	localparam int RAND_TXNS = 150;

	// Expected response, data only compared when check_data is set
	typedef struct packed {
		logic check_data;
		mem_rsp_t rsp;
	} exp_rsp_t;

	logic clk;
	logic rst_n;
	logic req_valid_a;
	logic req_valid_b;
	mem_req_t req_a;
	mem_req_t req_b;
	logic rsp_valid_a;
	logic rsp_valid_b;
	mem_rsp_t rsp_a;
	mem_rsp_t rsp_b;

	// Shadow memory: written data and number of injected flips
	data_t shadow_data [`ECC_RAM_WORDS];
	int shadow_flips [`ECC_RAM_WORDS];
	// One queue of expected responses per port
	exp_rsp_t exp_a [$];
	exp_rsp_t exp_b [$];
	logic [31:0] lcg_state;

	ecc_mem_top UUT (
		.clk(clk), .rst_n(rst_n),
		.req_valid_a(req_valid_a), .req_valid_b(req_valid_b),
		.req_a(req_a), .req_b(req_b),
		.rsp_valid_a(rsp_valid_a), .rsp_valid_b(rsp_valid_b),
		.rsp_a(rsp_a), .rsp_b(rsp_b)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Mask with 0, 1 or 2 distinct flipped positions
	function automatic codeword_t make_mask(input int flips);
		codeword_t m;
		int p0;
		int p1;
		m = '0;
		p0 = int'(lcg_next() % 32'(BLOCK_BITS));
		// Offset 1..BLOCK_BITS-1 keeps the second flip off the first
		p1 = (p0 + 1 + int'(lcg_next() % 32'(BLOCK_BITS - 1))) % BLOCK_BITS;
		if (flips >= 1)
			m[p0] = 1'b1;
		if (flips >= 2)
			m[p1] = 1'b1;
		return m;
	endfunction

	function automatic mem_req_t make_req(input logic wr, input int addr, input data_t d,
			input codeword_t mask);
		mem_req_t r;
		r.write = wr;
		r.addr = addr_t'(addr);
		r.wdata = d;
		r.flip_mask = mask;
		return r;
	endfunction

	// Expected response from the shadow state before the request applies
	function automatic exp_rsp_t ref_response(input mem_req_t r);
		exp_rsp_t e;
		e.check_data = 1'b1;
		e.rsp.write = r.write;
		e.rsp.rdata = '0;
		e.rsp.status = ecc_ok;
		if (!r.write) begin
			e.rsp.rdata = shadow_data[r.addr];
			case (shadow_flips[r.addr])
				0: e.rsp.status = ecc_ok;
				1: e.rsp.status = ecc_corrected;
				default: begin
					// Double error, data is not meaningful
					e.rsp.status = ecc_uncorrectable;
					e.check_data = 1'b0;
				end
			endcase
		end
		return e;
	endfunction

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		abort_run($sformatf("[FAIL] %0t: %s", $time, msg));
	endtask

	task automatic check_rsp_data(input data_t got, input data_t exp, input string tag);
		if (got !== exp)
			report_mismatch($sformatf("%s rdata %h, expected %h", tag, got, exp));
	endtask

	task automatic check_rsp_status(input ecc_status_t got, input ecc_status_t exp,
			input string tag);
		if (got !== exp)
			report_mismatch($sformatf("%s status %s, expected %s", tag, got.name(), exp.name()));
	endtask

	task automatic check_rsp_kind(input logic got, input logic exp, input string tag);
		if (got !== exp)
			report_mismatch($sformatf("%s write flag %b, expected %b", tag, got, exp));
	endtask

	task automatic compare_port(input logic port, input mem_rsp_t got);
		exp_rsp_t e;
		string tag;
		tag = port ? "port b" : "port a";
		if (port ? (exp_b.size() == 0) : (exp_a.size() == 0)) begin
			abort_run($sformatf("Response on %s with no request outstanding", tag));
		end else begin
			if (port)
				e = exp_b.pop_front();
			else
				e = exp_a.pop_front();
			check_rsp_kind(got.write, e.rsp.write, tag);
			check_rsp_status(got.status, e.rsp.status, tag);
			if (e.check_data)
				check_rsp_data(got.rdata, e.rsp.rdata, tag);
		end
	endtask

	// Outputs settle after the rising edge, sample them on the falling one
	always @(negedge clk) begin
		if (rst_n) begin
			if (rsp_valid_a)
				compare_port(1'b0, rsp_a);
			if (rsp_valid_b)
				compare_port(1'b1, rsp_b);
		end
	end

	// One strobe, then wait until the compare process has consumed the response
	task automatic issue(input logic port, input mem_req_t r);
		int waited;
		@(posedge clk);
		if (port) begin
			exp_b.push_back(ref_response(r));
			req_b <= r;
			req_valid_b <= 1'b1;
		end else begin
			exp_a.push_back(ref_response(r));
			req_a <= r;
			req_valid_a <= 1'b1;
		end
		if (r.write) begin
			shadow_data[r.addr] = r.wdata;
			shadow_flips[r.addr] = $countones(r.flip_mask);
		end
		@(posedge clk);
		if (port)
			req_valid_b <= 1'b0;
		else
			req_valid_a <= 1'b0;
		waited = 0;
		while (port ? (exp_b.size() != 0) : (exp_a.size() != 0)) begin
			@(posedge clk);
			waited++;
			if (waited > RSP_TIMEOUT)
				abort_run($sformatf("Port %s got no response within %0d cycles",
					port ? "b" : "a", RSP_TIMEOUT));
		end
	endtask

	// Write then read back one address with a given mask
	task automatic write_read(input logic port, input int addr, input codeword_t mask);
		data_t d;
		d = {lcg_next(), lcg_next()};
		issue(port, make_req(1'b1, addr, d, mask));
		issue(port, make_req(1'b0, addr, '0, '0));
	endtask

	// Mixed traffic confined to 32 addresses starting at base
	task automatic rand_traffic(input logic port, input int base);
		logic [31:0] roll;
		for (int n = 0; n < RAND_TXNS; n++) begin
			roll = lcg_next();
			if (roll[0])
				issue(port, make_req(1'b1, base + int'(roll[8:4]), {lcg_next(), lcg_next()},
					make_mask(int'(roll[17:16]) % 3)));
			else
				issue(port, make_req(1'b0, base + int'(roll[8:4]), '0, '0));
		end
	endtask

	initial begin
		codeword_t mask;
		clk = 1'b0;
		rst_n = 1'b0;
		req_valid_a = 1'b0;
		req_valid_b = 1'b0;
		req_a = '0;
		req_b = '0;
		lcg_state = 32'h933525b7;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		// Clean fill of every word, both ports at once on split halves
		fork
			for (int i = 0; i < 32; i++)
				issue(1'b0, make_req(1'b1, i, {lcg_next(), lcg_next()}, '0));
			for (int i = 32; i < 64; i++)
				issue(1'b1, make_req(1'b1, i, {lcg_next(), lcg_next()}, '0));
		join

		// Clean write and read back on each port
		write_read(1'b0, 5, '0);
		write_read(1'b1, 40, '0);

		// Single flip at every codeword position, bit 0 and check bits included
		for (int p = 0; p < BLOCK_BITS; p++) begin
			mask = '0;
			mask[p] = 1'b1;
			write_read(logic'(p % 2), p % `ECC_RAM_WORDS, mask);
		end

		// Double flips, every position paired with a different one
		for (int p = 0; p < BLOCK_BITS; p++) begin
			mask = '0;
			mask[p] = 1'b1;
			mask[(p + 1 + (p * 7) % (BLOCK_BITS - 1)) % BLOCK_BITS] = 1'b1;
			write_read(logic'(p % 2), (p * 3) % `ECC_RAM_WORDS, mask);
		end

		// Strobes from both ports in the same cycle
		for (int n = 0; n < 12; n++) begin
			fork
				issue(1'b0, make_req(logic'(n % 2 == 0), n, {lcg_next(), lcg_next()}, '0));
				issue(1'b1, make_req(logic'(n % 2 == 0), 32 + n, {lcg_next(), lcg_next()},
					make_mask(n % 3)));
			join
		end

		// Random traffic on both ports together
		fork
			rand_traffic(1'b0, 0);
			rand_traffic(1'b1, 32);
		join

		$display("All checks passed");
		$finish;
	end

endmodule

//--- verilog/bus_pkg.sv
`include "ecc_consts.svh"

package bus_pkg;

	import ecc_pkg::*;

	typedef logic [`ECC_ADDR_BITS-1:0] addr_t;
	typedef logic [`ECC_DATA_BITS-1:0] data_t;

	// Request from one port
	// flip_mask is XORed into the stored codeword for error injection
	typedef struct packed {
		logic write;
		addr_t addr;
		data_t wdata;
		codeword_t flip_mask;
	} mem_req_t;

	// Response to one port
	// Write acknowledges carry zero data and ecc_ok
	typedef struct packed {
		logic write;
		data_t rdata;
		ecc_status_t status;
	} mem_rsp_t;

	// Command on the shared pipeline, tagged with its source port
	typedef struct packed {
		logic port;
		mem_req_t req;
	} mem_cmd_t;

endpackage

//--- verilog/codeword_ram.sv
`include "ecc_consts.svh"

module codeword_ram (
	input logic clk,
	input logic rst_n,
	input logic valid,
	input logic write,
	input bus_pkg::addr_t addr,
	input ecc_pkg::codeword_t wr_word,
	input ecc_pkg::codeword_t flip_mask,
	input logic port_in,
	output logic rd_valid,
	output logic ack,
	output logic port_out,
	output ecc_pkg::codeword_t rd_word
);

	import ecc_pkg::*;

	codeword_t mem [`ECC_RAM_WORDS];

	// Response kind, one cycle after the command
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
			ack <= 1'b0;
		end else begin
			rd_valid <= valid & ~write;
			ack <= valid & write;
		end
	end

	always_ff @(posedge clk) begin
		// Injected flips are stored as part of the word
		if (valid && write)
			mem[addr] <= wr_word ^ flip_mask;
		// Registered read port
		if (valid && !write)
			rd_word <= mem[addr];
		// Source port for either kind of response
		if (valid)
			port_out <= port_in;
	end

	a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
		valid |-> (int'(addr) < `ECC_RAM_WORDS));

endmodule

//--- verilog/ecc_consts.svh
`ifndef ECC_CONSTS_SVH
`define ECC_CONSTS_SVH

// Payload bits carried by one memory word
`define ECC_DATA_BITS 64

// Word address width
`define ECC_ADDR_BITS 6

// Number of codewords held by the RAM
`define ECC_RAM_WORDS 64

`endif

//--- verilog/ecc_mem_top.sv
module ecc_mem_top (
	input logic clk,
	input logic rst_n,
	input logic req_valid_a,
	input logic req_valid_b,
	input bus_pkg::mem_req_t req_a,
	input bus_pkg::mem_req_t req_b,
	output logic rsp_valid_a,
	output logic rsp_valid_b,
	output bus_pkg::mem_rsp_t rsp_a,
	output bus_pkg::mem_rsp_t rsp_b
);

	import ecc_pkg::*;
	import bus_pkg::*;

	logic cmd_valid;
	mem_cmd_t cmd;
	// Command fields that ride beside the encoder
	mem_cmd_t cmd_q;
	logic enc_valid;
	codeword_t enc_word;
	logic rd_valid;
	logic ack;
	logic ram_port;
	codeword_t rd_word;
	// Write ack and port, delayed beside the decoder
	logic ack_q;
	logic port_q;
	logic dec_valid;
	data_t dec_data;
	ecc_status_t dec_status;
	logic rsp_valid;
	mem_rsp_t rsp;

	port_arbiter u_arb (
		.clk(clk), .rst_n(rst_n),
		.req_valid_a(req_valid_a), .req_valid_b(req_valid_b),
		.req_a(req_a), .req_b(req_b),
		.cmd_valid(cmd_valid), .cmd(cmd)
	);

	hamming_encoder u_enc (
		.clk(clk), .rst_n(rst_n),
		.valid_in(cmd_valid), .data_in(cmd.req.wdata),
		.valid_out(enc_valid), .data_out(enc_word)
	);

	always_ff @(posedge clk) begin
		if (cmd_valid)
			cmd_q <= cmd;
	end

	codeword_ram u_ram (
		.clk(clk), .rst_n(rst_n),
		.valid(enc_valid), .write(cmd_q.req.write), .addr(cmd_q.req.addr),
		.wr_word(enc_word), .flip_mask(cmd_q.req.flip_mask), .port_in(cmd_q.port),
		.rd_valid(rd_valid), .ack(ack), .port_out(ram_port), .rd_word(rd_word)
	);

	hamming_decoder u_dec (
		.clk(clk), .rst_n(rst_n),
		.valid_in(rd_valid), .data_in(rd_word),
		.valid_out(dec_valid), .data_out(dec_data), .status(dec_status)
	);

	always_ff @(posedge clk) begin
		if (!rst_n)
			ack_q <= 1'b0;
		else
			ack_q <= ack;
	end

	always_ff @(posedge clk) begin
		if (rd_valid || ack)
			port_q <= ram_port;
	end

	// Reads and write acks leave in pipeline order, never in the same cycle
	assign rsp_valid = dec_valid | ack_q;
	assign rsp.write = ack_q;
	assign rsp.rdata = ack_q ? '0 : dec_data;
	assign rsp.status = ack_q ? ecc_ok : dec_status;

	// Steer by source port
	assign rsp_valid_a = rsp_valid & ~port_q;
	assign rsp_valid_b = rsp_valid & port_q;
	assign rsp_a = rsp;
	assign rsp_b = rsp;

endmodule

//--- verilog/ecc_pkg.sv
`include "ecc_consts.svh"

package ecc_pkg;

	// One check bit per address bit of the codeword, plus the extra SECDED bit
	localparam int FEC_BITS = $clog2(`ECC_DATA_BITS) + 1;

	// Data, check bits and global parity in bit 0
	localparam int BLOCK_BITS = `ECC_DATA_BITS + FEC_BITS + 1;

	typedef logic [BLOCK_BITS-1:0] codeword_t;

	typedef enum logic [1:0] {
		ecc_ok,
		ecc_corrected,
		ecc_uncorrectable
	} ecc_status_t;

	// Position syndrome points at the flipped bit, parity_err flags an odd error count
	typedef struct packed {
		logic [FEC_BITS-1:0] position;
		logic parity_err;
	} syndrome_t;

	// Codeword position of data bit k
	// Positions 0 and the powers of two are skipped, data starts at 3
	function automatic int data_pos(input int k);
		int pos;
		pos = 3;
		for (int n = 0; n < k; n++) begin
			pos++;
			// Two powers of two are never adjacent above 2, one skip is enough
			if ((pos & (pos - 1)) == 0)
				pos++;
		end
		return pos;
	endfunction

endpackage

//--- verilog/hamming_decoder.sv
`include "ecc_consts.svh"

module hamming_decoder #(
	parameter int DATA_BITS = `ECC_DATA_BITS
) (
	input logic clk,
	input logic rst_n,
	input logic valid_in,
	input ecc_pkg::codeword_t data_in,
	output logic valid_out,
	output logic [DATA_BITS-1:0] data_out,
	output ecc_pkg::ecc_status_t status
);

	import ecc_pkg::*;

	localparam int FEC = $clog2(DATA_BITS) + 1;
	localparam int BLK = DATA_BITS + FEC + 1;

	logic [BLK-1:0] word;
	logic [BLK-1:0] fixed;
	logic acc;
	syndrome_t syn;
	ecc_status_t st;
	logic [DATA_BITS-1:0] data;

	always_comb begin
		word = BLK'(data_in);
		// Parity over the whole word with bit 0 included
		syn.parity_err = ^word;
		// Position syndrome recomputed over the stored check bits too
		for (int i = 0; i < FEC; i++) begin
			acc = 1'b0;
			for (int j = 1; j < BLK; j++) begin
				if (((j >> i) & 1) != 0)
					acc = acc ^ word[j];
			end
			syn.position[i] = acc;
		end

		fixed = word;
		st = ecc_ok;
		if (syn.parity_err) begin
			// Odd error count means one bad bit, which gets flipped
			// Position 0 means the global parity bit itself
			if (int'(syn.position) < BLK) begin
				fixed[syn.position] = ~fixed[syn.position];
				st = ecc_corrected;
			end else begin
				// Points outside the word, so more than one bit is bad
				st = ecc_uncorrectable;
			end
		end else if (syn.position != '0) begin
			// Even count with a nonzero syndrome is a double error
			// Data goes out as received
			st = ecc_uncorrectable;
		end

		// Gather data bits back out of the codeword
		for (int k = 0; k < DATA_BITS; k++)
			data[k] = fixed[data_pos(k)];
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			valid_out <= 1'b0;
		else
			valid_out <= valid_in;
	end

	always_ff @(posedge clk) begin
		data_out <= data;
		status <= st;
	end

	// Reads only hit written words, so a valid output has a known status
	a_status_known: assert property (@(posedge clk) disable iff (!rst_n)
		valid_out |-> !$isunknown(status));

endmodule

//--- verilog/hamming_encoder.sv
`include "ecc_consts.svh"

module hamming_encoder #(
	parameter int DATA_BITS = `ECC_DATA_BITS
) (
	input logic clk,
	input logic rst_n,
	input logic valid_in,
	input logic [DATA_BITS-1:0] data_in,
	output logic valid_out,
	output ecc_pkg::codeword_t data_out
);

	import ecc_pkg::*;

	// Code geometry for this data width
	localparam int FEC = $clog2(DATA_BITS) + 1;
	localparam int BLK = DATA_BITS + FEC + 1;

	logic [BLK-1:0] word;
	logic chk;

	always_comb begin
		word = '0;
		// Scatter data into the non-power-of-two slots
		for (int k = 0; k < DATA_BITS; k++)
			word[data_pos(k)] = data_in[k];
		// Check bit i sits at 2**i and covers every position with bit i set
		// Its own slot is still zero here, so including it is harmless
		for (int i = 0; i < FEC; i++) begin
			chk = 1'b0;
			for (int j = 1; j < BLK; j++) begin
				if (((j >> i) & 1) != 0)
					chk = chk ^ word[j];
			end
			word[1 << i] = chk;
		end
		// Global parity over everything above bit 0
		word[0] = ^word[BLK-1:1];
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			valid_out <= 1'b0;
		else
			valid_out <= valid_in;
	end

	// Codeword register
	always_ff @(posedge clk) begin
		data_out <= codeword_t'(word);
	end

endmodule

//--- verilog/port_arbiter.sv
module port_arbiter (
	input logic clk,
	input logic rst_n,
	input logic req_valid_a,
	input logic req_valid_b,
	input bus_pkg::mem_req_t req_a,
	input bus_pkg::mem_req_t req_b,
	output logic cmd_valid,
	output bus_pkg::mem_cmd_t cmd
);

	import bus_pkg::*;

	// One pending slot per port
	mem_req_t slot_a;
	mem_req_t slot_b;
	logic full_a;
	logic full_b;
	// Port b wins a tie when set
	logic prio_b;

	logic have_a;
	logic have_b;
	logic grant_a;
	logic grant_b;
	mem_req_t cur_a;
	mem_req_t cur_b;

	// A fresh strobe competes in its own cycle, so an idle grant costs one cycle
	always_comb begin
		have_a = full_a | req_valid_a;
		have_b = full_b | req_valid_b;
		cur_a = full_a ? slot_a : req_a;
		cur_b = full_b ? slot_b : req_b;
		grant_a = have_a & (~have_b | ~prio_b);
		grant_b = have_b & ~grant_a;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			full_a <= 1'b0;
			full_b <= 1'b0;
			prio_b <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			full_a <= have_a & ~grant_a;
			full_b <= have_b & ~grant_b;
			cmd_valid <= grant_a | grant_b;
			// Loser of this grant goes first next time
			if (grant_a)
				prio_b <= 1'b1;
			else if (grant_b)
				prio_b <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid_a && !full_a)
			slot_a <= req_a;
		if (req_valid_b && !full_b)
			slot_b <= req_b;
		if (grant_a)
			cmd <= '{port: 1'b0, req: cur_a};
		else if (grant_b)
			cmd <= '{port: 1'b1, req: cur_b};
	end

	// Ports keep one request outstanding, so a full slot never sees a strobe
	a_no_overrun_a: assert property (@(posedge clk) disable iff (!rst_n)
		full_a |-> !req_valid_a);
	a_no_overrun_b: assert property (@(posedge clk) disable iff (!rst_n)
		full_b |-> !req_valid_b);
	// A parked request lost the last grant and wins the next one
	a_rr_grant_a: assert property (@(posedge clk) disable iff (!rst_n)
		full_a |-> grant_a);
	a_rr_grant_b: assert property (@(posedge clk) disable iff (!rst_n)
		full_b |-> grant_b);

endmodule
